// File: i2c_pkg.sv
/*
 * shared definitions for the I2C EEPROM master
 * bus phase timing, field widths, command bit positions,
 * sequencer state type and buffer load selector
 */

package i2c_pkg;

	//************************************************************
	// timing
	//************************************************************
	localparam int TICK_CLKS = 667;            // clocks per bus half-cycle
	localparam int TICK_W    = 10;             // phase counter width

	//************************************************************
	// field widths
	//************************************************************
	localparam int DEV_W     = 7;              // device identifier
	localparam int ADDR_W    = 8;              // word address
	localparam int BYTE_W    = 8;
	localparam int DATA_W    = 16;             // data_out / data_in
	localparam int BIT_CNT_W = 3;              // bit index within a byte
	localparam int CMD_W     = 2;

	// command strobe positions
	localparam int CMD_WRITE_BIT = 1;
	localparam int CMD_READ_BIT  = 0;

	// last bit of the device address byte
	localparam logic RW_WRITE = 1'b0;
	localparam logic RW_READ  = 1'b1;

	// scl low / high phases of every bus step
	typedef enum logic [4:0] {
		st_idle,
		st_start,
		st_dev_bit_low,
		st_dev_bit_high,
		st_dev_ack_low,
		st_dev_ack_high,
		st_addr_bit_low,
		st_addr_bit_high,
		st_addr_ack_low,
		st_addr_ack_high,
		st_data_bit_low,
		st_data_bit_high,
		st_data_ack_low,
		st_data_ack_high,
		st_restart_low,
		st_restart_high,
		st_rd_bit_low,
		st_rd_bit_high,
		st_mack_low,
		st_mack_high,
		st_stop_low,
		st_stop_high,
		st_release
	} seq_state_t;

	typedef enum logic [1:0] {
		load_dev_wr,                           // device id + write bit
		load_dev_rd,                           // device id + read bit
		load_addr,
		load_data
	} buf_load_t;

endpackage

// File: i2c_cmd_front.sv
/*
 * command front end
 * strobe decode, write protect, operand latches, busy and fail
 */

`timescale 1ns/1ps

module i2c_cmd_front (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [i2c_pkg::CMD_W-1:0]   command,
	input  logic                        two_bytes,
	input  logic                        software_wp,
	input  logic [i2c_pkg::DEV_W-1:0]   dev_id,
	input  logic [i2c_pkg::ADDR_W-1:0]  add,
	input  logic [i2c_pkg::DATA_W-1:0]  data_out,
	input  logic                        done,
	input  logic                        nack,
	output logic                        start_req,
	output logic                        is_read,
	output logic                        two_bytes_q,
	output logic [i2c_pkg::DEV_W-1:0]   dev_q,
	output logic [i2c_pkg::ADDR_W-1:0]  addr_q,
	output logic [i2c_pkg::DATA_W-1:0]  wdata_q,
	output logic                        busy,
	output logic                        fail
);

	logic wr_stb;
	logic rd_stb;
	logic accept;
	logic refuse;
	logic closing;                             // done seen, waiting for idle strobes

	assign wr_stb = command[i2c_pkg::CMD_WRITE_BIT];
	assign rd_stb = command[i2c_pkg::CMD_READ_BIT];

	// write has priority when both strobes come together
	assign accept = !busy && ((wr_stb && !software_wp) || (rd_stb && !wr_stb));
	assign refuse = !busy && wr_stb && software_wp;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			start_req   <= 1'b0;
			is_read     <= 1'b0;
			two_bytes_q <= 1'b0;
			busy        <= 1'b0;
			closing     <= 1'b0;
			fail        <= 1'b0;
		end
		else
		begin
			start_req <= accept;
			if (accept)
			begin
				is_read     <= !wr_stb;
				two_bytes_q <= two_bytes;
				busy        <= 1'b1;
				closing     <= 1'b0;
			end
			else if (busy && (done || closing))
			begin
				// operation ends only with both strobes low
				if (command == '0)
				begin
					busy    <= 1'b0;
					closing <= 1'b0;
				end
				else
					closing <= 1'b1;
			end

			if (accept)
				fail <= 1'b0;
			else if (nack || refuse)
				fail <= 1'b1;                  // missing ack or protected write
		end
	end

	// operands held for the whole operation
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			dev_q   <= dev_id;
			addr_q  <= add;
			wdata_q <= data_out;
		end
	end

endmodule

// File: i2c_byte_buf.sv
/*
 * byte buffer between command front end and bus sequencer
 * outgoing shift register, receive register and data_in slots
 */

`timescale 1ns/1ps

module i2c_byte_buf (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [i2c_pkg::DEV_W-1:0]   dev_q,
	input  logic [i2c_pkg::ADDR_W-1:0]  addr_q,
	input  logic [i2c_pkg::DATA_W-1:0]  wdata_q,
	input  logic                        two_bytes_q,
	input  logic                        load,
	input  i2c_pkg::buf_load_t          load_sel,
	input  logic                        shift,
	input  logic                        sda_in,
	input  logic                        rx_commit,
	output logic                        tx_bit,
	output logic [i2c_pkg::DATA_W-1:0]  data_in
);

	logic [i2c_pkg::BYTE_W-1:0] tx_sr;
	logic [i2c_pkg::BYTE_W-1:0] rx_sr;
	logic                       byte_ptr;      // 0 = high byte next in two-byte ops

	assign tx_bit = tx_sr[i2c_pkg::BYTE_W-1];  // msb first

	//************************************************************
	// shift registers
	//************************************************************
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			case (load_sel)
				i2c_pkg::load_dev_wr: tx_sr <= {dev_q, i2c_pkg::RW_WRITE};
				i2c_pkg::load_dev_rd: tx_sr <= {dev_q, i2c_pkg::RW_READ};
				i2c_pkg::load_addr:   tx_sr <= addr_q;
				default:
					tx_sr <= (two_bytes_q && !byte_ptr) ? wdata_q[15:8] : wdata_q[7:0];
			endcase
		end
		else if (shift)
		begin
			tx_sr <= {tx_sr[i2c_pkg::BYTE_W-2:0], 1'b0};
			rx_sr <= {rx_sr[i2c_pkg::BYTE_W-2:0], sda_in}; // sampled while scl high
		end
	end

	//************************************************************
	// byte pointer and read data
	//************************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			byte_ptr <= 1'b0;
			data_in  <= '0;
		end
		else if (load && load_sel == i2c_pkg::load_dev_wr)
			byte_ptr <= 1'b0;                  // every operation starts here
		else if (load && load_sel == i2c_pkg::load_data)
			byte_ptr <= two_bytes_q && !byte_ptr;
		else if (rx_commit)
		begin
			if (two_bytes_q && !byte_ptr)
			begin
				data_in[15:8] <= rx_sr;        // first of two bytes
				byte_ptr      <= 1'b1;
			end
			else if (two_bytes_q)
			begin
				data_in[7:0] <= rx_sr;
				byte_ptr     <= 1'b0;
			end
			else
				data_in <= {8'h00, rx_sr};
		end
	end

endmodule

// File: i2c_bus_seq.sv
/*
 * bus sequencer
 * phase timer, bit counter and the start / address / data /
 * acknowledge / restart / stop state machine driving scl and sda
 */

`timescale 1ns/1ps

module i2c_bus_seq (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start_req,
	input  logic                is_read,
	input  logic                two_bytes_q,
	input  logic                tx_bit,
	input  logic                sda_in,
	output logic                load,
	output i2c_pkg::buf_load_t  load_sel,
	output logic                shift,
	output logic                rx_commit,
	output logic                done,
	output logic                nack,
	output logic                scl,
	output logic                sda_oe
);

	localparam logic [i2c_pkg::TICK_W-1:0] TICK_LAST =
		i2c_pkg::TICK_W'(i2c_pkg::TICK_CLKS - 1);
	localparam logic [i2c_pkg::BIT_CNT_W-1:0] BIT_LAST =
		i2c_pkg::BIT_CNT_W'(i2c_pkg::BYTE_W - 1);

	i2c_pkg::seq_state_t             state;
	logic [i2c_pkg::TICK_W-1:0]      phase_cnt;
	logic                            tick;
	logic [i2c_pkg::BIT_CNT_W-1:0]   bit_cnt;
	logic                            second_byte;  // second byte of a two-byte op
	logic                            rd_phase;     // past the repeated start
	logic                            req_pend;
	logic                            more_bytes;

	//************************************************************
	// phase timer
	//************************************************************
	assign tick = (phase_cnt == TICK_LAST);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			phase_cnt <= '0;
		else if (tick)
			phase_cnt <= '0;
		else
			phase_cnt <= phase_cnt + 1'b1;
	end

	assign more_bytes = two_bytes_q && !second_byte;

	//************************************************************
	// state machine, advances on tick only
	//************************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= i2c_pkg::st_idle;
			scl         <= 1'b1;
			sda_oe      <= 1'b0;
			bit_cnt     <= '0;
			second_byte <= 1'b0;
			rd_phase    <= 1'b0;
			req_pend    <= 1'b0;
			load        <= 1'b0;
			load_sel    <= i2c_pkg::load_dev_wr;
			shift       <= 1'b0;
			rx_commit   <= 1'b0;
			done        <= 1'b0;
			nack        <= 1'b0;
		end
		else
		begin
			load      <= 1'b0;
			shift     <= 1'b0;
			rx_commit <= 1'b0;
			done      <= 1'b0;
			nack      <= 1'b0;
			if (start_req)
				req_pend <= 1'b1;              // held until the next idle tick

			if (tick)
			begin
				case (state)
					i2c_pkg::st_idle:
						if (req_pend)
						begin
							state       <= i2c_pkg::st_start;
							sda_oe      <= 1'b1;   // sda falls, scl high
							req_pend    <= 1'b0;
							bit_cnt     <= '0;
							second_byte <= 1'b0;
							rd_phase    <= 1'b0;
							load        <= 1'b1;
							load_sel    <= i2c_pkg::load_dev_wr;
						end
					i2c_pkg::st_start:
					begin
						state  <= i2c_pkg::st_dev_bit_low;
						scl    <= 1'b0;
						sda_oe <= !tx_bit;
					end

					// bit high phases: present bit on the bus
					i2c_pkg::st_dev_bit_low:
					begin
						state <= i2c_pkg::st_dev_bit_high;
						scl   <= 1'b1;
						shift <= 1'b1;
					end
					i2c_pkg::st_addr_bit_low:
					begin
						state <= i2c_pkg::st_addr_bit_high;
						scl   <= 1'b1;
						shift <= 1'b1;
					end
					i2c_pkg::st_data_bit_low:
					begin
						state <= i2c_pkg::st_data_bit_high;
						scl   <= 1'b1;
						shift <= 1'b1;
					end
					i2c_pkg::st_rd_bit_low:
					begin
						state <= i2c_pkg::st_rd_bit_high;
						scl   <= 1'b1;
						shift <= 1'b1;             // samples sda_in
					end

					// bit low phases: next bit or release for ack
					i2c_pkg::st_dev_bit_high:
					begin
						scl     <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						sda_oe  <= (bit_cnt == BIT_LAST) ? 1'b0 : !tx_bit;
						state   <= (bit_cnt == BIT_LAST) ? i2c_pkg::st_dev_ack_low
							: i2c_pkg::st_dev_bit_low;
					end
					i2c_pkg::st_addr_bit_high:
					begin
						scl     <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						sda_oe  <= (bit_cnt == BIT_LAST) ? 1'b0 : !tx_bit;
						state   <= (bit_cnt == BIT_LAST) ? i2c_pkg::st_addr_ack_low
							: i2c_pkg::st_addr_bit_low;
					end
					i2c_pkg::st_data_bit_high:
					begin
						scl     <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						sda_oe  <= (bit_cnt == BIT_LAST) ? 1'b0 : !tx_bit;
						state   <= (bit_cnt == BIT_LAST) ? i2c_pkg::st_data_ack_low
							: i2c_pkg::st_data_bit_low;
					end
					i2c_pkg::st_rd_bit_high:
					begin
						scl     <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_LAST)
						begin
							state     <= i2c_pkg::st_mack_low;
							sda_oe    <= more_bytes;   // ack low between two bytes
							rx_commit <= 1'b1;
						end
						else
							state <= i2c_pkg::st_rd_bit_low;
					end

					// ack high phases, next byte loaded in advance
					i2c_pkg::st_dev_ack_low:
					begin
						state <= i2c_pkg::st_dev_ack_high;
						scl   <= 1'b1;
						if (!rd_phase)
						begin
							load     <= 1'b1;
							load_sel <= i2c_pkg::load_addr;
						end
					end
					i2c_pkg::st_addr_ack_low:
					begin
						state    <= i2c_pkg::st_addr_ack_high;
						scl      <= 1'b1;
						load     <= 1'b1;
						load_sel <= is_read ? i2c_pkg::load_dev_rd : i2c_pkg::load_data;
					end
					i2c_pkg::st_data_ack_low:
					begin
						state <= i2c_pkg::st_data_ack_high;
						scl   <= 1'b1;
						if (more_bytes)
						begin
							load     <= 1'b1;
							load_sel <= i2c_pkg::load_data;
						end
					end
					i2c_pkg::st_mack_low:
					begin
						state <= i2c_pkg::st_mack_high;
						scl   <= 1'b1;
					end

					// ack checks, sda_in sampled while scl still high
					i2c_pkg::st_dev_ack_high:
					begin
						scl <= 1'b0;
						if (sda_in)
						begin
							nack   <= 1'b1;
							state  <= i2c_pkg::st_stop_low;
							sda_oe <= 1'b1;
						end
						else if (rd_phase)
							state <= i2c_pkg::st_rd_bit_low;
						else
						begin
							state  <= i2c_pkg::st_addr_bit_low;
							sda_oe <= !tx_bit;
						end
					end
					i2c_pkg::st_addr_ack_high:
					begin
						scl <= 1'b0;
						if (sda_in)
						begin
							nack   <= 1'b1;
							state  <= i2c_pkg::st_stop_low;
							sda_oe <= 1'b1;
						end
						else if (is_read)
							state <= i2c_pkg::st_restart_low;  // sda stays released
						else
						begin
							state  <= i2c_pkg::st_data_bit_low;
							sda_oe <= !tx_bit;
						end
					end
					i2c_pkg::st_data_ack_high:
					begin
						scl <= 1'b0;
						if (sda_in || !more_bytes)
						begin
							nack   <= sda_in;
							state  <= i2c_pkg::st_stop_low;
							sda_oe <= 1'b1;
						end
						else
						begin
							state       <= i2c_pkg::st_data_bit_low;
							sda_oe      <= !tx_bit;
							second_byte <= 1'b1;
						end
					end
					i2c_pkg::st_mack_high:
					begin
						scl         <= 1'b0;
						second_byte <= 1'b1;
						sda_oe      <= !more_bytes;    // low for stop, else released
						state       <= more_bytes ? i2c_pkg::st_rd_bit_low
							: i2c_pkg::st_stop_low;
					end

					//************************************************************
					// repeated start and stop
					//************************************************************
					i2c_pkg::st_restart_low:
					begin
						state <= i2c_pkg::st_restart_high;
						scl   <= 1'b1;
					end
					i2c_pkg::st_restart_high:
					begin
						state    <= i2c_pkg::st_start;
						sda_oe   <= 1'b1;
						rd_phase <= 1'b1;
					end
					i2c_pkg::st_stop_low:
					begin
						state <= i2c_pkg::st_stop_high;
						scl   <= 1'b1;
					end
					i2c_pkg::st_stop_high:
					begin
						state  <= i2c_pkg::st_release;
						sda_oe <= 1'b0;            // sda rises while scl high
					end
					i2c_pkg::st_release:
					begin
						state <= i2c_pkg::st_idle;
						done  <= 1'b1;
					end
					default:
					begin
						state  <= i2c_pkg::st_idle;
						scl    <= 1'b1;
						sda_oe <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

// File: i2c_master.sv
/*
 * I2C EEPROM master top level
 * command front end, byte buffer and bus sequencer
 */

`timescale 1ns/1ps

module i2c_master (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [i2c_pkg::CMD_W-1:0]   command,
	input  logic                        two_bytes,
	input  logic                        software_wp,
	input  logic [i2c_pkg::DEV_W-1:0]   dev_id,
	input  logic [i2c_pkg::ADDR_W-1:0]  add,
	input  logic [i2c_pkg::DATA_W-1:0]  data_out,
	input  logic                        sda_in,
	output logic                        busy,
	output logic                        fail,
	output logic [i2c_pkg::DATA_W-1:0]  data_in,
	output logic                        scl,
	output logic                        sda_oe     // 1 pulls sda low
);

	// front end to buffer and sequencer
	logic                        start_req;
	logic                        is_read;
	logic                        two_bytes_q;
	logic [i2c_pkg::DEV_W-1:0]   dev_q;
	logic [i2c_pkg::ADDR_W-1:0]  addr_q;
	logic [i2c_pkg::DATA_W-1:0]  wdata_q;

	// sequencer handshakes
	logic                        done;
	logic                        nack;
	logic                        load;
	i2c_pkg::buf_load_t          load_sel;
	logic                        shift;
	logic                        rx_commit;
	logic                        tx_bit;

	i2c_cmd_front cmd_front_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.command     (command),
		.two_bytes   (two_bytes),
		.software_wp (software_wp),
		.dev_id      (dev_id),
		.add         (add),
		.data_out    (data_out),
		.done        (done),
		.nack        (nack),
		.start_req   (start_req),
		.is_read     (is_read),
		.two_bytes_q (two_bytes_q),
		.dev_q       (dev_q),
		.addr_q      (addr_q),
		.wdata_q     (wdata_q),
		.busy        (busy),
		.fail        (fail)
	);

	i2c_byte_buf byte_buf_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.dev_q       (dev_q),
		.addr_q      (addr_q),
		.wdata_q     (wdata_q),
		.two_bytes_q (two_bytes_q),
		.load        (load),
		.load_sel    (load_sel),
		.shift       (shift),
		.sda_in      (sda_in),
		.rx_commit   (rx_commit),
		.tx_bit      (tx_bit),
		.data_in     (data_in)
	);

	i2c_bus_seq bus_seq_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start_req   (start_req),
		.is_read     (is_read),
		.two_bytes_q (two_bytes_q),
		.tx_bit      (tx_bit),
		.sda_in      (sda_in),
		.load        (load),
		.load_sel    (load_sel),
		.shift       (shift),
		.rx_commit   (rx_commit),
		.done        (done),
		.nack        (nack),
		.scl         (scl),
		.sda_oe      (sda_oe)
	);

endmodule

// File: eeprom_model.sv
/*
 * behavioral I2C EEPROM slave with a 256-byte memory
 * answers device 7'h50, random write and read with address auto-increment
 */

`timescale 1ns/1ps

module eeprom_model (
	input  logic clk,
	input  logic rst_n,
	input  logic scl,
	input  logic sda,
	output logic sda_oe                        // 1 pulls sda low
);

	localparam logic [6:0] DEV_ID = 7'h50;

	typedef enum logic [2:0] {m_idle, m_rx, m_ack, m_tx, m_mack} mode_t;

	mode_t      mode;
	logic [7:0] mem [0:255];
	logic       scl_r;
	logic       sda_r;
	logic [3:0] bit_n;
	logic [7:0] rx_sh;
	logic [7:0] tx_sh;
	logic [7:0] ptr;                           // word address pointer
	logic       first_byte;                    // next byte is the device byte
	logic       addr_next;
	logic       rd_dir;
	logic       macked;
	logic       start_c;
	logic       stop_c;
	logic       rise;
	logic       fall;

	// bus events seen on the system clock
	assign start_c = scl_r && scl && sda_r && !sda;
	assign stop_c  = scl_r && scl && !sda_r && sda;
	assign rise    = !scl_r && scl;
	assign fall    = scl_r && !scl;

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i[7:0]] = i[7:0] ^ 8'h5a;      // power-up content
	end

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode       <= m_idle;
			scl_r      <= 1'b1;
			sda_r      <= 1'b1;
			sda_oe     <= 1'b0;
			bit_n      <= 4'd0;
			rx_sh      <= 8'h00;
			tx_sh      <= 8'h00;
			ptr        <= 8'h00;
			first_byte <= 1'b0;
			addr_next  <= 1'b0;
			rd_dir     <= 1'b0;
			macked     <= 1'b0;
		end
		else
		begin
			scl_r <= scl;
			sda_r <= sda;
			if (start_c)
			begin
				mode       <= m_rx;
				bit_n      <= 4'd0;
				first_byte <= 1'b1;
				sda_oe     <= 1'b0;
			end
			else if (stop_c)
			begin
				mode   <= m_idle;
				sda_oe <= 1'b0;
			end
			else
				case (mode)
					m_rx:
						if (rise)
						begin
							rx_sh <= {rx_sh[6:0], sda};
							bit_n <= bit_n + 4'd1;
						end
						else if (fall && bit_n == 4'd8)
						begin
							first_byte <= 1'b0;
							if (first_byte && rx_sh[7:1] != DEV_ID)
								mode <= m_idle;    // not addressed, no ack
							else
							begin
								mode   <= m_ack;
								sda_oe <= 1'b1;
								if (first_byte)
								begin
									rd_dir    <= rx_sh[0];
									addr_next <= !rx_sh[0];
								end
								else if (addr_next)
								begin
									ptr       <= rx_sh;
									addr_next <= 1'b0;
								end
								else
								begin
									mem[ptr] <= rx_sh;
									ptr      <= ptr + 8'd1;
								end
							end
						end
					m_ack:
						if (fall && rd_dir)
						begin
							mode   <= m_tx;        // first data bit right away
							sda_oe <= !mem[ptr][7];
							tx_sh  <= {mem[ptr][6:0], 1'b0};
							bit_n  <= 4'd1;
						end
						else if (fall)
						begin
							mode   <= m_rx;
							sda_oe <= 1'b0;
							bit_n  <= 4'd0;
						end
					m_tx:
						if (fall && bit_n == 4'd8)
						begin
							mode   <= m_mack;
							sda_oe <= 1'b0;        // master acknowledges
							ptr    <= ptr + 8'd1;
						end
						else if (fall)
						begin
							sda_oe <= !tx_sh[7];
							tx_sh  <= {tx_sh[6:0], 1'b0};
							bit_n  <= bit_n + 4'd1;
						end
					m_mack:
						if (rise)
							macked <= !sda;
						else if (fall && macked)
						begin
							mode   <= m_tx;
							sda_oe <= !mem[ptr][7];
							tx_sh  <= {mem[ptr][6:0], 1'b0};
							bit_n  <= 4'd1;
						end
						else if (fall)
							mode <= m_idle;        // no ack, wait for stop
					default:
						mode <= m_idle;
				endcase
		end
	end

endmodule

// File: i2c_checker.sv
/*
 * concurrent assertions bound to the I2C master
 * bus pins move on phase ticks, refused writes, sda stable under scl high
 */

`timescale 1ns/1ps

module i2c_checker (
	input logic                        clk,
	input logic                        rst_n,
	input i2c_pkg::seq_state_t         state,
	input logic                        scl,
	input logic                        sda_oe,
	input logic                        busy,
	input logic                        fail,
	input logic [i2c_pkg::CMD_W-1:0]   command,
	input logic                        software_wp
);

	logic [i2c_pkg::TICK_W-1:0] phase;         // clocks into the current bus phase
	logic                       refused;

	assign refused = !busy && command[i2c_pkg::CMD_WRITE_BIT] && software_wp;

	// phases start at reset release and last TICK_CLKS clocks each
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= '0;
		else if (phase == i2c_pkg::TICK_W'(i2c_pkg::TICK_CLKS - 1))
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	// scl and sda_oe register their new value on a tick
	bus_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
		(scl != $past(scl) || sda_oe != $past(sda_oe)) |->
		($past(phase) == i2c_pkg::TICK_W'(i2c_pkg::TICK_CLKS - 1)))
		else $error("scl or sda_oe changed without a phase tick");

	refuse_no_busy: assert property (@(posedge clk) disable iff (!rst_n)
		$past(refused) |-> (fail && !busy))
		else $error("refused write raised busy or left fail low");

	// only start, repeated start and stop move sda under scl high
	sda_stable_high: assert property (@(posedge clk) disable iff (!rst_n)
		(scl && $past(scl) && sda_oe != $past(sda_oe)) |->
		($past(state) inside {i2c_pkg::st_idle, i2c_pkg::st_restart_high,
			i2c_pkg::st_stop_high}))
		else $error("sda_oe changed while scl was high outside start or stop");

endmodule

// File: tb_i2c_master.sv
/*
 * testbench for the I2C EEPROM master
 * clock and reset, operations from the golden file, open-drain sda,
 * result checks, watchdog and closing report
 */

`timescale 1ns/1ps

module tb_i2c_master;

	localparam int N_COLS  = 8;                // fields per golden line
	localparam int MAX_OPS = 128;
	localparam logic [15:0] OP_READ       = 16'h0001;
	localparam logic [15:0] OP_WRITE_BUSY = 16'h0002;  // write, then a strobe while busy
	localparam logic [15:0] OP_END        = 16'hffff;

	logic                               clk;
	logic                               rst_n;
	logic [i2c_pkg::CMD_W-1:0]          command;
	logic                               two_bytes;
	logic                               software_wp;
	logic [i2c_pkg::DEV_W-1:0]          dev_id;
	logic [i2c_pkg::ADDR_W-1:0]         add;
	logic [i2c_pkg::DATA_W-1:0]         data_out;
	logic                               busy;
	logic                               fail;
	logic [i2c_pkg::DATA_W-1:0]         data_in;
	logic                               scl;
	logic                               sda_oe;
	logic                               slave_oe;
	wire                                sda;

	logic [15:0] golden [0:MAX_OPS*N_COLS-1];
	int          n_ops;
	int          checks;
	int          errors;
	logic        loaded = 1'b0;

	assign sda = !(sda_oe || slave_oe);       // pulled up unless someone drives low

	i2c_master dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.command     (command),
		.two_bytes   (two_bytes),
		.software_wp (software_wp),
		.dev_id      (dev_id),
		.add         (add),
		.data_out    (data_out),
		.sda_in      (sda),
		.busy        (busy),
		.fail        (fail),
		.data_in     (data_in),
		.scl         (scl),
		.sda_oe      (sda_oe)
	);

	eeprom_model slave_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.scl    (scl),
		.sda    (sda),
		.sda_oe (slave_oe)
	);

	bind i2c_master i2c_checker checker_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.state       (bus_seq_i.state),
		.scl         (scl),
		.sda_oe      (sda_oe),
		.busy        (busy),
		.fail        (fail),
		.command     (command),
		.software_wp (software_wp)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;                // 20 ns period
	end

	function automatic logic [15:0] golden_field(input int op_idx, input int col);
		return golden[10'(op_idx * N_COLS + col)];
	endfunction

	task automatic note_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t ns: %s", $time, msg);
	endtask

	//************************************************************
	// one operation: strobe, wait for busy to fall, check
	//************************************************************
	task automatic run_op(input int idx);
		logic [15:0] op;
		logic        exp_busy;
		logic        exp_fail;
		logic [15:0] exp_data;
		op       = golden_field(idx, 0);
		exp_data = golden_field(idx, 6);
		exp_fail = golden_field(idx, 7) != 16'h0;
		@(posedge clk);
		#2;
		dev_id      = 7'(golden_field(idx, 1));
		add         = 8'(golden_field(idx, 2));
		data_out    = golden_field(idx, 3);
		two_bytes   = golden_field(idx, 4) != 16'h0;
		software_wp = golden_field(idx, 5) != 16'h0;
		command     = (op == OP_READ) ? 2'b01 : 2'b10;
		exp_busy    = !(op != OP_READ && software_wp);  // protected write is refused
		@(posedge clk);
		#2;
		command = 2'b00;
		checks++;
		if (busy != exp_busy)
			note_mismatch($sformatf("op %0d busy is %0b, expected %0b", idx, busy, exp_busy));
		if (op == OP_WRITE_BUSY)
		begin
			repeat (3) @(posedge clk);
			#2;
			data_out = ~data_out;              // must never reach the memory
			command  = 2'b10;
			@(posedge clk);
			#2;
			command = 2'b00;
		end
		while (busy)
		begin
			@(posedge clk);
			#2;
		end
		checks++;
		if (fail != exp_fail)
			note_mismatch($sformatf("op %0d fail is %0b, expected %0b", idx, fail, exp_fail));
		if (op == OP_READ && !exp_fail)
		begin
			checks++;
			if (data_in != exp_data)
				note_mismatch($sformatf("op %0d data_in is %h, expected %h",
					idx, data_in, exp_data));
		end
	endtask

	initial
	begin : main
		command     = '0;
		two_bytes   = 1'b0;
		software_wp = 1'b0;
		dev_id      = '0;
		add         = '0;
		data_out    = '0;
		rst_n       = 1'b0;
		checks      = 0;
		errors      = 0;
		for (int i = 0; i < MAX_OPS * N_COLS; i++)
			golden[10'(i)] = OP_END;
		$readmemh("i2c_golden.txt", golden);
		n_ops = 0;
		while (n_ops < MAX_OPS && golden_field(n_ops, 0) != OP_END)
			n_ops++;
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		checks++;
		if (busy || fail || sda_oe || !scl || data_in != '0)
			note_mismatch("outputs not at their reset values");
		for (int i = 0; i < n_ops; i++)
			run_op(i);
		$display("%0d operations, %0d checks, %0d errors", n_ops, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// limit scales with the number of operations
	initial
	begin : watchdog
		longint limit_ns;
		wait (loaded);
		limit_ns = longint'(n_ops);
		limit_ns = limit_ns * 70 * 20 * longint'(i2c_pkg::TICK_CLKS);
		#(limit_ns);
		$display("Simulation timed out after %0d ns", limit_ns);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: i2c_golden.txt
// op(0 write, 1 read, 2 write with a strobe while busy) dev_id add data_out
// two_bytes software_wp expected_data_in expected_fail, data checked on good reads
0000 0050 0010 00a7 0000 0000 0000 0000
0001 0050 0010 0000 0000 0000 00a7 0000
0000 0050 0020 1234 0001 0000 0000 0000
0001 0050 0020 0000 0001 0000 1234 0000
0000 0050 0030 005c 0000 0000 0000 0000
0000 0050 0030 0099 0000 0001 0000 0001
0001 0050 0030 0000 0000 0000 005c 0000
0000 0051 0040 0011 0000 0000 0000 0001
0001 0023 0040 0000 0000 0000 0000 0001
0001 0050 0080 0000 0000 0000 00da 0000
0002 0050 0050 beef 0001 0000 0000 0000
0001 0050 0050 0000 0001 0000 beef 0000
0001 0050 0021 0000 0000 0000 0034 0000

// File: all.f
i2c_pkg.sv
i2c_cmd_front.sv
i2c_byte_buf.sv
i2c_bus_seq.sv
i2c_master.sv
eeprom_model.sv
i2c_checker.sv
tb_i2c_master.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module tb_i2c_master -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "All checks passed"; then
	exit 0
else
	exit 1
fi
